// ==== Makefile ====
# Verilator build and run for the DMA register file

VERILATOR ?= verilator
TOP ?= dmaRegFileTb
FILELIST ?= dmaRegFile.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS ?= --binary --timing --assert --timescale $(TIMESCALE)
LINTFLAGS ?= --lint-only -Wall --timing --timescale $(TIMESCALE)
FAIL_MSG ?= SIMULATION FAILED

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@./$(BINARY) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dmaRegFile.f ====
hdl/dmaRegPkg.sv
hdl/cpuPortDecoder.sv
hdl/dmaChannel.sv
hdl/readbackMux.sv
hdl/dmaRegFile.sv
verification/dmaRegFileTb.sv

// ==== hdl/cpuPortDecoder.sv ====
// CPU port decoder
`default_nettype none

module cpuPortDecoder #(
  parameter int numChannels = dmaRegPkg::maxChannels
) (
  input  wire logic                dif,
  input  wire logic                arstN,
  input  wire logic                csN,
  input  wire logic                iorN,
  input  wire logic                iowN,
  input  wire dmaRegPkg::ioAddrT   addr,
  input  wire dmaRegPkg::dataByteT dataIn,
  input  wire logic                stepValid,
  input  wire dmaRegPkg::chanIdT   stepChannel,
  output dmaRegPkg::chanCmdT       chanCmd [numChannels],
  output dmaRegPkg::readReqT       readReq
);

  logic wrCycle;
  logic rdCycle;
  logic chanAccess;
  logic ptrClear;
  logic bytePtr;

  assign wrCycle = !csN && !iowN;
  assign rdCycle = !csN && !iorN;
  // addresses 0..7 are the channel address and count registers
  assign chanAccess = (wrCycle || rdCycle) && !addr[3];
  assign ptrClear = wrCycle &&
                    (addr == dmaRegPkg::addrClearFlipFlop || addr == dmaRegPkg::addrMasterClear);

  // byte pointer: 0 = low byte next
  always_ff @(posedge dif or negedge arstN)
  begin
    if (!arstN)
    begin
      bytePtr <= 1'b0;
    end
    else if (ptrClear)
    begin
      bytePtr <= 1'b0;
    end
    else if (chanAccess)
    begin
      bytePtr <= ~bytePtr;
    end
  end

  for (genvar c = 0; c < numChannels; c++)
  begin : gCmd
    localparam dmaRegPkg::chanIdT chanId = dmaRegPkg::chanIdT'(c);

    logic regHit;
    logic selHit;
    logic allMaskBit;
    dmaRegPkg::chanCmdT cmd;

    assign regHit = !addr[3] && addr[2:1] == chanId;
    // mode and single-mask writes carry the channel in data bits 1..0
    assign selHit = dataIn[1:0] == chanId;
    assign allMaskBit = dataIn[c];

    always_comb
    begin
      cmd = '0;
      cmd.loadAddr = wrCycle && regHit && !addr[0];
      cmd.loadCount = wrCycle && regHit && addr[0];
      cmd.highByte = bytePtr;
      cmd.data = dataIn;
      cmd.loadMode = wrCycle && addr == dmaRegPkg::addrMode && selHit;
      cmd.autoInit = dataIn[dmaRegPkg::modeAutoInitBit];
      cmd.decrement = dataIn[dmaRegPkg::modeDecrementBit];
      cmd.maskSet = wrCycle &&
                    ((addr == dmaRegPkg::addrSingleMask && selHit &&
                      dataIn[dmaRegPkg::singleMaskSetBit]) ||
                     (addr == dmaRegPkg::addrWriteAllMask && allMaskBit));
      cmd.maskClear = wrCycle &&
                      ((addr == dmaRegPkg::addrSingleMask && selHit &&
                        !dataIn[dmaRegPkg::singleMaskSetBit]) ||
                       (addr == dmaRegPkg::addrWriteAllMask && !allMaskBit) ||
                       addr == dmaRegPkg::addrClearMask);
      // status read clears every channel's flag
      cmd.clearTc = rdCycle && addr == dmaRegPkg::addrStatus;
      cmd.masterClear = wrCycle && addr == dmaRegPkg::addrMasterClear;
      // a CPU write to this channel wins, the step is dropped
      cmd.step = stepValid && stepChannel == chanId &&
                 !(cmd.loadAddr || cmd.loadCount || cmd.loadMode ||
                   cmd.maskSet || cmd.maskClear || cmd.masterClear);
    end

    assign chanCmd[c] = cmd;
  end

  always_comb
  begin
    readReq.valid = rdCycle && (!addr[3] || addr == dmaRegPkg::addrStatus);
    readReq.isStatus = addr == dmaRegPkg::addrStatus;
    readReq.isCount = addr[0];
    readReq.channel = addr[2:1];
    readReq.highByte = bytePtr;
  end

  // CPU must not read and write in one cycle
  noReadWriteClash: assert property (
    @(posedge dif) disable iff (!arstN)
    !csN |-> (iorN || iowN)
  );

endmodule : cpuPortDecoder

`default_nettype wire

// ==== hdl/dmaChannel.sv ====
// DMA channel register set
`default_nettype none

module dmaChannel (
  input  wire logic               dif,
  input  wire logic               arstN,
  input  wire dmaRegPkg::chanCmdT cmd,
  output dmaRegPkg::chanStateT    state
);

  dmaRegPkg::regWordT baseAddr;
  dmaRegPkg::regWordT baseCount;
  dmaRegPkg::regWordT currAddr;
  dmaRegPkg::regWordT currCount;
  dmaRegPkg::regWordT nextAddr;
  logic autoInit;
  logic decrement;
  logic masked;
  logic tcFlag;
  logic stepTaken;
  logic countZero;

  // replace one byte of a register word
  function automatic dmaRegPkg::regWordT loadByte(
    input dmaRegPkg::regWordT  word,
    input logic                high,
    input dmaRegPkg::dataByteT data
  );
    dmaRegPkg::regWordT result;
    result = word;
    if (high)
    begin
      result[15:8] = data;
    end
    else
    begin
      result[7:0] = data;
    end
    return result;
  endfunction

  assign stepTaken = cmd.step && !masked;
  assign countZero = currCount == '0;
  assign nextAddr = decrement ? currAddr - dmaRegPkg::regWordT'(1)
                              : currAddr + dmaRegPkg::regWordT'(1);

  always_ff @(posedge dif or negedge arstN)
  begin
    if (!arstN)
    begin
      baseAddr <= '0;
      baseCount <= '0;
      currAddr <= '0;
      currCount <= '0;
      autoInit <= 1'b0;
      decrement <= 1'b0;
      masked <= 1'b0;
      tcFlag <= 1'b0;
    end
    else if (cmd.masterClear)
    begin
      baseAddr <= '0;
      baseCount <= '0;
      currAddr <= '0;
      currCount <= '0;
      autoInit <= 1'b0;
      decrement <= 1'b0;
      masked <= 1'b0;
      tcFlag <= 1'b0;
    end
    else
    begin
      // CPU writes load base and current together
      if (cmd.loadAddr)
      begin
        baseAddr <= loadByte(baseAddr, cmd.highByte, cmd.data);
        currAddr <= loadByte(currAddr, cmd.highByte, cmd.data);
      end
      if (cmd.loadCount)
      begin
        baseCount <= loadByte(baseCount, cmd.highByte, cmd.data);
        currCount <= loadByte(currCount, cmd.highByte, cmd.data);
      end
      if (cmd.loadMode)
      begin
        autoInit <= cmd.autoInit;
        decrement <= cmd.decrement;
      end
      if (cmd.maskSet)
      begin
        masked <= 1'b1;
      end
      else if (cmd.maskClear)
      begin
        masked <= 1'b0;
      end
      if (cmd.clearTc)
      begin
        tcFlag <= 1'b0;
      end
      // a new terminal count beats a status-read clear
      if (stepTaken)
      begin
        if (countZero && autoInit)
        begin
          currAddr <= baseAddr;
          currCount <= baseCount;
        end
        else
        begin
          currAddr <= nextAddr;
          currCount <= currCount - dmaRegPkg::regWordT'(1);
        end
        if (countZero)
        begin
          tcFlag <= 1'b1;
          if (!autoInit)
          begin
            masked <= 1'b1;
          end
        end
      end
    end
  end

  always_comb
  begin
    state.currAddr = currAddr;
    state.currCount = currCount;
    state.tcFlag = tcFlag;
    state.stepped = stepTaken;
    // terminal count when the count passes from zero
    state.tcPulse = stepTaken && countZero;
    state.memAddr = currAddr;
  end

  // a step never shares a cycle with a CPU write to this channel
  stepWithoutWrite: assert property (
    @(posedge dif) disable iff (!arstN)
    cmd.step |-> !(cmd.loadAddr || cmd.loadCount || cmd.loadMode ||
                   cmd.maskSet || cmd.maskClear || cmd.masterClear)
  );

endmodule : dmaChannel

`default_nettype wire

// ==== hdl/dmaRegFile.sv ====
// DMA controller register file
`default_nettype none

module dmaRegFile #(
  parameter int numChannels = 4
) (
  input  wire logic                dif,
  input  wire logic                arstN,
  input  wire logic                csN,
  input  wire logic                iorN,
  input  wire logic                iowN,
  input  wire dmaRegPkg::ioAddrT   addr,
  input  wire dmaRegPkg::dataByteT dataIn,
  input  wire logic                stepValid,
  input  wire dmaRegPkg::chanIdT   stepChannel,
  output dmaRegPkg::dataByteT      dataOut,
  output dmaRegPkg::regWordT       memAddr,
  output logic                     tc
);

  dmaRegPkg::chanCmdT chanCmd [numChannels];
  dmaRegPkg::chanStateT chanState [numChannels];
  dmaRegPkg::readReqT readReq;

  // address map has room for maxChannels at most
  if (numChannels < 1 || numChannels > dmaRegPkg::maxChannels)
  begin : gBadChannelCount
    $error("numChannels must be between 1 and %0d", dmaRegPkg::maxChannels);
  end

  cpuPortDecoder #(
    .numChannels (numChannels)
  ) i_decoder (
    .dif         (dif),
    .arstN       (arstN),
    .csN         (csN),
    .iorN        (iorN),
    .iowN        (iowN),
    .addr        (addr),
    .dataIn      (dataIn),
    .stepValid   (stepValid),
    .stepChannel (stepChannel),
    .chanCmd     (chanCmd),
    .readReq     (readReq)
  );

  for (genvar c = 0; c < numChannels; c++)
  begin : gChannel
    dmaChannel i_channel (
      .dif   (dif),
      .arstN (arstN),
      .cmd   (chanCmd[c]),
      .state (chanState[c])
    );
  end

  readbackMux #(
    .numChannels (numChannels)
  ) i_readback (
    .dif       (dif),
    .arstN     (arstN),
    .readReq   (readReq),
    .chanState (chanState),
    .dataOut   (dataOut),
    .memAddr   (memAddr),
    .tc        (tc)
  );

endmodule : dmaRegFile

`default_nettype wire

// ==== hdl/dmaRegPkg.sv ====
// DMA register file definitions
`default_nettype none

package dmaRegPkg;

  // channel count the address map can hold
  localparam int maxChannels = 4;

  localparam int dataWidth = 8;
  localparam int wordWidth = 16;
  localparam int chanIdWidth = $clog2(maxChannels);
  localparam int ioAddrWidth = 4;

  typedef logic [dataWidth-1:0] dataByteT;
  typedef logic [wordWidth-1:0] regWordT;
  typedef logic [chanIdWidth-1:0] chanIdT;
  typedef logic [ioAddrWidth-1:0] ioAddrT;

  // 0..7 are channel registers: bit 0 picks count, bits 2..1 the channel
  localparam ioAddrT addrStatus = 4'd8;
  localparam ioAddrT addrSingleMask = 4'd10;
  localparam ioAddrT addrMode = 4'd11;
  localparam ioAddrT addrClearFlipFlop = 4'd12;
  localparam ioAddrT addrMasterClear = 4'd13;
  localparam ioAddrT addrClearMask = 4'd14;
  localparam ioAddrT addrWriteAllMask = 4'd15;

  // data bit positions of the mode and single-mask writes
  localparam int modeAutoInitBit = 4;
  localparam int modeDecrementBit = 5;
  localparam int singleMaskSetBit = 2;

  // decoded command for one channel
  typedef struct packed {
    logic     loadAddr;
    logic     loadCount;
    logic     highByte;
    dataByteT data;
    logic     loadMode;
    logic     autoInit;
    logic     decrement;
    logic     maskSet;
    logic     maskClear;
    logic     clearTc;
    logic     masterClear;
    logic     step;
  } chanCmdT;

  // what a channel reports back
  typedef struct packed {
    regWordT currAddr;
    regWordT currCount;
    logic    tcFlag;
    logic    stepped;
    logic    tcPulse;
    regWordT memAddr;
  } chanStateT;

  // CPU read request, byte pointer already resolved
  typedef struct packed {
    logic   valid;
    logic   isStatus;
    logic   isCount;
    chanIdT channel;
    logic   highByte;
  } readReqT;

endpackage : dmaRegPkg

`default_nettype wire

// ==== hdl/readbackMux.sv ====
// CPU readback and step output stage
`default_nettype none

module readbackMux #(
  parameter int numChannels = dmaRegPkg::maxChannels
) (
  input  wire logic                 dif,
  input  wire logic                 arstN,
  input  wire dmaRegPkg::readReqT   readReq,
  input  wire dmaRegPkg::chanStateT chanState [numChannels],
  output dmaRegPkg::dataByteT       dataOut,
  output dmaRegPkg::regWordT        memAddr,
  output logic                      tc
);

  dmaRegPkg::regWordT selWord;
  dmaRegPkg::regWordT stepAddr;
  dmaRegPkg::dataByteT readByte;
  logic [dmaRegPkg::maxChannels-1:0] tcFlags;
  logic [numChannels-1:0] steppedVec;
  logic stepTc;

  always_comb
  begin
    selWord = '0;
    stepAddr = '0;
    stepTc = 1'b0;
    tcFlags = '0;
    for (int c = 0; c < numChannels; c++)
    begin
      tcFlags[c] = chanState[c].tcFlag;
      steppedVec[c] = chanState[c].stepped;
      // channels past numChannels never match, so they read zero
      if (dmaRegPkg::chanIdT'(c) == readReq.channel)
      begin
        selWord = readReq.isCount ? chanState[c].currCount : chanState[c].currAddr;
      end
      if (chanState[c].stepped)
      begin
        stepAddr = chanState[c].memAddr;
        stepTc = chanState[c].tcPulse;
      end
    end
  end

  // status upper nibble reads zero
  always_comb
  begin
    if (readReq.isStatus)
    begin
      readByte = {{(dmaRegPkg::dataWidth - dmaRegPkg::maxChannels){1'b0}}, tcFlags};
    end
    else
    begin
      readByte = readReq.highByte ? selWord[15:8] : selWord[7:0];
    end
  end

  always_ff @(posedge dif or negedge arstN)
  begin
    if (!arstN)
    begin
      dataOut <= '0;
      memAddr <= '0;
      tc <= 1'b0;
    end
    else
    begin
      if (readReq.valid)
      begin
        dataOut <= readByte;
      end
      // masked steps leave memAddr alone
      if (|steppedVec)
      begin
        memAddr <= stepAddr;
      end
      tc <= stepTc;
    end
  end

  // decoder routes each step to one channel only
  singleStepper: assert property (
    @(posedge dif) disable iff (!arstN)
    $onehot0(steppedVec)
  );

endmodule : readbackMux

`default_nettype wire

// ==== verification/dmaRegFileTb.sv ====
// DMA register file testbench
`default_nettype none

module dmaRegFileTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam string traceFile = "verification/dmaRegTrace.txt";
  localparam int halfPeriod = 10;
  localparam int resetCycles = 5;
  localparam int maxGap = 3;
  localparam int maxOps = 1000;
  localparam int runLimitNs = 1000000;

  logic dif;
  logic arstN;
  logic csN;
  logic iorN;
  logic iowN;
  dmaRegPkg::ioAddrT addr;
  dmaRegPkg::dataByteT dataIn;
  logic stepValid;
  dmaRegPkg::chanIdT stepChannel;
  dmaRegPkg::dataByteT dataOut;
  dmaRegPkg::regWordT memAddr;
  logic tc;

  // mismatches and other failures are counted apart
  int errors;
  int failures;

  dmaRegFile #(
    .numChannels (4)
  ) i_dut (
    .dif         (dif),
    .arstN       (arstN),
    .csN         (csN),
    .iorN        (iorN),
    .iowN        (iowN),
    .addr        (addr),
    .dataIn      (dataIn),
    .stepValid   (stepValid),
    .stepChannel (stepChannel),
    .dataOut     (dataOut),
    .memAddr     (memAddr),
    .tc          (tc)
  );

  initial
  begin
    dif = 1'b0;
  end

  always #(halfPeriod * 1ns) dif = ~dif;

  task automatic checkByte(input string name, input dmaRegPkg::dataByteT expected,
                           input dmaRegPkg::dataByteT actual);
    if (actual !== expected)
    begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic checkWord(input string name, input dmaRegPkg::regWordT expected,
                           input dmaRegPkg::regWordT actual);
    if (actual !== expected)
    begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic checkFlag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      errors++;
      $display("** Error %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  task automatic idleCycles(input int count);
    for (int i = 0; i < count; i++)
    begin
      @(posedge dif);
    end
  endtask

  // reset low for a fixed number of edges, outputs start at zero
  task automatic applyReset();
    idleCycles(resetCycles);
    arstN <= 1'b1;
    @(negedge dif);
    checkByte("reset dataOut", '0, dataOut);
    checkWord("reset memAddr", '0, memAddr);
    checkFlag("reset tc", 1'b0, tc);
  endtask

  task automatic writeRegister(input dmaRegPkg::ioAddrT a, input dmaRegPkg::dataByteT d);
    @(posedge dif);
    csN <= 1'b0;
    iowN <= 1'b0;
    addr <= a;
    dataIn <= d;
    @(posedge dif);
    csN <= 1'b1;
    iowN <= 1'b1;
  endtask

  // dataOut is registered at the sampling edge, checked mid-cycle
  task automatic readRegister(input dmaRegPkg::ioAddrT a, input dmaRegPkg::dataByteT expected,
                              input string name);
    @(posedge dif);
    csN <= 1'b0;
    iorN <= 1'b0;
    addr <= a;
    @(posedge dif);
    csN <= 1'b1;
    iorN <= 1'b1;
    @(negedge dif);
    checkByte(name, expected, dataOut);
  endtask

  task automatic issueStep(input dmaRegPkg::chanIdT ch, input dmaRegPkg::regWordT expAddr,
                           input logic expTc, input string name);
    @(posedge dif);
    stepValid <= 1'b1;
    stepChannel <= ch;
    @(posedge dif);
    stepValid <= 1'b0;
    @(negedge dif);
    checkWord({name, " memAddr"}, expAddr, memAddr);
    checkFlag({name, " tc"}, expTc, tc);
  endtask

  task automatic skipComment(input int fd);
    int ch;
    ch = 0;
    while (ch != 10 && ch != -1)
    begin
      ch = $fgetc(fd);
    end
  endtask

  task automatic replayOp(input int fd, input byte opChar, input int opIndex);
    int code;
    int needed;
    logic [15:0] f1;
    logic [15:0] f2;
    logic [15:0] f3;
    code = 0;
    needed = 0;
    case (opChar)
      "W":
      begin
        needed = 2;
        code = $fscanf(fd, "%h %h", f1, f2);
        if (code == needed)
        begin
          writeRegister(dmaRegPkg::ioAddrT'(f1), dmaRegPkg::dataByteT'(f2));
        end
      end
      "R":
      begin
        needed = 2;
        code = $fscanf(fd, "%h %h", f1, f2);
        if (code == needed)
        begin
          readRegister(dmaRegPkg::ioAddrT'(f1), dmaRegPkg::dataByteT'(f2),
                       $sformatf("op %0d read addr %h", opIndex, f1[3:0]));
        end
      end
      "S":
      begin
        needed = 3;
        code = $fscanf(fd, "%h %h %h", f1, f2, f3);
        if (code == needed)
        begin
          issueStep(dmaRegPkg::chanIdT'(f1), f2, f3[0],
                    $sformatf("op %0d step ch %0d", opIndex, f1[1:0]));
        end
      end
      "I":
      begin
        needed = 1;
        code = $fscanf(fd, "%h", f1);
        if (code == needed)
        begin
          idleCycles(int'(f1));
        end
      end
      default:
      begin
        failures++;
        $display("op %0d has an unknown operation code", opIndex);
      end
    endcase
    if (needed != 0 && code != needed)
    begin
      failures++;
      $display("op %0d is missing its fields", opIndex);
    end
  endtask

  initial
  begin : mainFlow
    int fd;
    int code;
    int opCount;
    int gap;
    byte opChar;
    bit done;
    arstN = 1'b0;
    csN = 1'b1;
    iorN = 1'b1;
    iowN = 1'b1;
    addr = '0;
    dataIn = '0;
    stepValid = 1'b0;
    stepChannel = '0;
    errors = 0;
    failures = 0;
    opCount = 0;
    void'($urandom(32'h1d07));
    applyReset();
    fd = $fopen(traceFile, "r");
    if (fd == 0)
    begin
      failures++;
      $display("could not open trace file %s", traceFile);
    end
    else
    begin
      done = 1'b0;
      while (!done)
      begin
        code = $fscanf(fd, " %c", opChar);
        if (code != 1)
        begin
          done = 1'b1;
        end
        else if (opChar == "#")
        begin
          skipComment(fd);
        end
        else if (opCount >= maxOps)
        begin
          failures++;
          $display("trace holds more than %0d operations, replay stopped", maxOps);
          done = 1'b1;
        end
        else
        begin
          opCount++;
          replayOp(fd, opChar, opCount);
          gap = $urandom % (maxGap + 1);
          idleCycles(gap);
        end
      end
      $fclose(fd);
      if (opCount == 0)
      begin
        failures++;
        $display("trace file holds no operations");
      end
    end
    $display("%0d operations, %0d value errors, %0d other failures", opCount, errors, failures);
    if (errors == 0 && failures == 0)
    begin
      $display("SIMULATION PASSED");
    end
    else
    begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // last resort if the replay never reaches its end
  initial
  begin : watchdog
    #(runLimitNs * 1ns);
    $display("run did not finish within %0d ns", runLimitNs);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule : dmaRegFileTb

`default_nettype wire

// ==== verification/dmaRegTrace.txt ====
# W addr data | R addr expected | S channel memAddr tc | I idle cycles
# all values hex, one operation per line
W 0 34
W 0 12
W 1 03
W 1 00
R 0 34
R 0 12
R 1 03
R 1 00
R 0 34
W c 00
R 0 34
R 0 12
S 0 1234 0
S 0 1235 0
R 1 01
R 1 00
W b 21
W 2 00
W 2 20
W 3 05
W 3 00
S 1 2000 0
S 1 1fff 0
S 1 1ffe 0
R 3 02
R 3 00
I 2
S 0 1236 0
S 0 1237 1
R 8 01
R 8 00
S 0 1237 0
R 1 ff
R 1 ff
W b 12
W 4 00
W 4 40
W 5 01
W 5 00
S 2 4000 0
S 2 4001 1
R 5 01
R 5 00
R 8 04
S 2 4000 0
W 6 00
W 6 60
W 7 10
W 7 00
S 3 6000 0
W a 07
S 3 6000 0
W a 03
S 3 6001 0
W f 08
S 3 6001 0
S 1 1ffd 0
S 0 1238 0
W f 01
S 0 1238 0
S 3 6002 0
W e 00
S 0 1239 0
S 1 1ffc 0
S 1 1ffb 1
W f 0f
W d 00
R 8 00
R 0 00
R 0 00
R 7 00
R 7 00
S 0 0000 1
S 3 0000 1
R 8 09
